//--- source/cpu_pkg.sv
// RV32I subset definitions for the multi-cycle core
// opcodes, ALU operations, FSM states and register types
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;

    // major opcodes of the supported instructions
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        S_FETCH,
        S_DECODE,
        S_EXEC,
        S_MEM,
        S_WB,
        S_HALT
    } core_state_e;

    localparam word_t RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire

//--- source/bus_pkg.sv
// memory map of the byte-wide external bus
// address and data types plus the I/O region constants
`default_nettype none

package bus_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [7:0]  byte_t;

    // addr[17:16] == 3 selects I/O
    localparam logic [1:0] IO_SEL_HI = 2'd3;
    localparam addr_t IO_PORT_ADDR   = 32'h0003_0000;
    localparam addr_t IO_STOP_ADDR   = 32'h0003_0004;

    localparam int BYTES_PER_WORD = 4;

endpackage

`default_nettype wire

//--- source/mem_bus_if.sv
// word request channel between the core and the memory controller
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if
    import cpu_pkg::*, bus_pkg::*;
();

    logic  req;
    logic  we;
    addr_t addr;
    word_t wdata;
    word_t rdata;
    logic  done;

    modport core (output req, we, addr, wdata, input rdata, done);
    modport ctrl (input req, we, addr, wdata, output rdata, done);

endinterface

`default_nettype wire

//--- source/mem_ctrl.sv
// byte-serial memory controller
// turns one word request into four byte cycles on the external bus
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl
    import cpu_pkg::*, bus_pkg::*;
(
    input  logic       clk_in,
    input  logic       rst_in,
    input  logic       rdy_in,
    mem_bus_if.ctrl    bus,
    input  byte_t      mem_din_i,
    output byte_t      mem_dout_o,
    output addr_t      mem_addr_o,
    output logic       mem_wr_o
);

    localparam logic [2:0] LAST_IDX = 3'(BYTES_PER_WORD);

    logic       busy;
    logic [2:0] idx;
    logic       rd_pend;
    logic       done_q;
    word_t      rdata_q;
    logic [2:0] off;
    logic       last_step;

    // byte 0 goes out in the request cycle itself, idx counts the next byte
    // while paused in a read, hold the previous address so the RAM
    // still returns the byte that has not been sampled yet
    assign off = (rd_pend && (!rdy_in || idx == LAST_IDX)) ? idx - 3'd1 : idx;

    assign mem_addr_o = bus.addr + addr_t'(off);
    assign mem_dout_o = bus.wdata[{idx[1:0], 3'b000} +: 8];
    assign mem_wr_o   = rdy_in && bus.we && (busy || bus.req);

    // a read needs one more cycle to sample its last byte
    assign last_step = rd_pend ? (idx == LAST_IDX) : (idx == LAST_IDX - 3'd1);

    assign bus.rdata = rdata_q;
    assign bus.done  = done_q;

    always_ff @(posedge clk_in)
    begin
        if (rst_in)
        begin
            busy    <= 1'b0;
            idx     <= 3'd0;
            rd_pend <= 1'b0;
            done_q  <= 1'b0;
        end
        else if (rdy_in)
        begin
            done_q <= 1'b0;
            if (!busy)
            begin
                if (bus.req)
                begin
                    busy    <= 1'b1;
                    idx     <= 3'd1;
                    rd_pend <= !bus.we;
                end
            end
            else if (last_step)
            begin
                busy    <= 1'b0;
                idx     <= 3'd0;
                rd_pend <= 1'b0;
                done_q  <= 1'b1;
            end
            else
            begin
                idx <= idx + 3'd1;
            end
        end
    end

    // read bytes arrive low first, shift them in from the top
    always_ff @(posedge clk_in)
    begin
        if (rdy_in && busy && rd_pend)
        begin
            rdata_q <= {mem_din_i, rdata_q[31:8]};
        end
    end

endmodule

`default_nettype wire

//--- source/regfile.sv
// 32 x 32 register file, two combinational reads and one write
`timescale 1ns/1ps
`default_nettype none

module regfile
    import cpu_pkg::*;
(
    input  logic      clk_in,
    input  logic      rst_in,
    input  reg_addr_t raddr1_i,
    input  reg_addr_t raddr2_i,
    output word_t     rdata1_o,
    output word_t     rdata2_o,
    input  logic      we_i,
    input  reg_addr_t waddr_i,
    input  word_t     wdata_i
);

    word_t regs [32];

    assign rdata1_o = regs[raddr1_i];
    assign rdata2_o = regs[raddr2_i];

    always_ff @(posedge clk_in)
    begin
        if (rst_in)
        begin
            for (int i = 0; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        // x0 stays zero
        else if (we_i && waddr_i != '0)
        begin
            regs[waddr_i] <= wdata_i;
        end
    end

endmodule

`default_nettype wire

//--- source/cpu_core.sv
// multi-cycle RV32I core, one instruction at a time
// fetch, decode, execute, memory and writeback with its ALU
`timescale 1ns/1ps
`default_nettype none

module cpu_core
    import cpu_pkg::*, bus_pkg::*;
(
    input  logic      clk_in,
    input  logic      rst_in,
    input  logic      rdy_in,
    mem_bus_if.core   bus,
    output reg_addr_t rs1_addr_o,
    output reg_addr_t rs2_addr_o,
    input  word_t     rs1_data_i,
    input  word_t     rs2_data_i,
    output logic      rd_we_o,
    output reg_addr_t rd_addr_o,
    output word_t     rd_data_o,
    output logic      halted_o
);

    core_state_e state;
    addr_t       pc;
    logic        mem_open;
    logic        mem_req;
    word_t       ir_q;
    word_t       res_q;
    word_t       imm_q;
    addr_t       target_q;
    logic        taken_q;
    alu_op_e     alu_op_q;
    logic        use_imm_q;
    logic        wb_en_q;

    opcode_t     opcode;
    logic [2:0]  funct3;
    alu_op_e     dec_op;
    word_t       dec_imm;
    logic        dec_use_imm;
    logic        dec_wb;
    word_t       alu_b;
    word_t       alu_res;
    logic        is_mem;

    assign opcode = ir_q[6:0];
    assign funct3 = ir_q[14:12];
    assign is_mem = (opcode == OP_LOAD) || (opcode == OP_STORE);

    assign rs1_addr_o = ir_q[19:15];
    assign rs2_addr_o = ir_q[24:20];
    assign rd_addr_o  = ir_q[11:7];
    assign rd_data_o  = res_q;
    // no register write while the CPU is paused
    assign rd_we_o    = rdy_in && (state == S_WB) && wb_en_q;
    assign halted_o   = (state == S_HALT);

    // one request per fetch or memory state
    assign mem_req   = ((state == S_FETCH) || (state == S_MEM)) && !mem_open;
    assign bus.req   = mem_req;
    assign bus.we    = (state == S_MEM) && (opcode == OP_STORE);
    assign bus.addr  = (state == S_MEM) ? res_q : pc;
    assign bus.wdata = rs2_data_i;

    // decode
    always_comb
    begin
        dec_op      = ALU_ADD;
        dec_imm     = {{20{ir_q[31]}}, ir_q[31:20]};
        dec_use_imm = 1'b1;
        dec_wb      = 1'b0;
        case (opcode)
            OP_LUI:
            begin
                dec_op  = ALU_PASS_B;
                dec_imm = {ir_q[31:12], 12'b0};
                dec_wb  = 1'b1;
            end
            OP_IMM, OP_REG:
            begin
                dec_use_imm = (opcode == OP_IMM);
                dec_wb      = 1'b1;
                case (funct3)
                    3'b000: dec_op = (opcode == OP_REG && ir_q[30]) ? ALU_SUB : ALU_ADD;
                    3'b010: dec_op = ALU_SLT;
                    3'b100: dec_op = ALU_XOR;
                    3'b110: dec_op = ALU_OR;
                    3'b111: dec_op = ALU_AND;
                    // shifts and unsigned compares are not implemented
                    default: dec_wb = 1'b0;
                endcase
            end
            OP_LOAD:
            begin
                dec_wb = 1'b1;
            end
            OP_STORE:
            begin
                dec_imm = {{20{ir_q[31]}}, ir_q[31:25], ir_q[11:7]};
            end
            OP_BRANCH:
            begin
                dec_imm = {{19{ir_q[31]}}, ir_q[31], ir_q[7], ir_q[30:25], ir_q[11:8], 1'b0};
            end
            OP_JAL:
            begin
                dec_imm = {{11{ir_q[31]}}, ir_q[31], ir_q[19:12], ir_q[20], ir_q[30:21], 1'b0};
                dec_wb  = 1'b1;
            end
            default: dec_wb = 1'b0;
        endcase
    end

    // ALU
    assign alu_b = use_imm_q ? imm_q : rs2_data_i;

    always_comb
    begin
        case (alu_op_q)
            ALU_ADD:    alu_res = rs1_data_i + alu_b;
            ALU_SUB:    alu_res = rs1_data_i - alu_b;
            ALU_AND:    alu_res = rs1_data_i & alu_b;
            ALU_OR:     alu_res = rs1_data_i | alu_b;
            ALU_XOR:    alu_res = rs1_data_i ^ alu_b;
            ALU_SLT:    alu_res = word_t'($signed(rs1_data_i) < $signed(alu_b));
            default:    alu_res = alu_b;
        endcase
    end

    always_ff @(posedge clk_in)
    begin
        if (rst_in)
        begin
            state    <= S_FETCH;
            pc       <= RESET_PC;
            mem_open <= 1'b0;
        end
        else if (rdy_in)
        begin
            if (mem_req)
                mem_open <= 1'b1;
            else if (bus.done)
                mem_open <= 1'b0;
            case (state)
                S_FETCH:  if (bus.done) state <= S_DECODE;
                S_DECODE: state <= S_EXEC;
                S_EXEC:   state <= is_mem ? S_MEM : S_WB;
                S_MEM:
                begin
                    if (bus.done)
                    begin
                        // a store to the stop register ends the program
                        if (bus.we && res_q == IO_STOP_ADDR)
                            state <= S_HALT;
                        else
                            state <= S_WB;
                    end
                end
                S_WB:
                begin
                    pc    <= taken_q ? target_q : pc + 32'd4;
                    state <= S_FETCH;
                end
                default: state <= S_HALT;
            endcase
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (rdy_in)
        begin
            if (state == S_FETCH && bus.done)
                ir_q <= bus.rdata;
            if (state == S_DECODE)
            begin
                alu_op_q  <= dec_op;
                imm_q     <= dec_imm;
                use_imm_q <= dec_use_imm;
                wb_en_q   <= dec_wb;
            end
            if (state == S_EXEC)
            begin
                // JAL links pc+4, loads and stores keep the address here
                res_q    <= (opcode == OP_JAL) ? pc + 32'd4 : alu_res;
                target_q <= pc + imm_q;
                taken_q  <= (opcode == OP_JAL) ||
                            (opcode == OP_BRANCH && funct3 == 3'b000 &&
                             rs1_data_i == rs2_data_i);
            end
            if (state == S_MEM && bus.done && opcode == OP_LOAD)
                res_q <= bus.rdata;
        end
    end

endmodule

`default_nettype wire

//--- source/riscv_soc.sv
// RV32I subsystem top: core, register file and byte-serial memory controller
`timescale 1ns/1ps
`default_nettype none

module riscv_soc
    import cpu_pkg::*, bus_pkg::*;
(
    input  logic  clk_in,
    input  logic  rst_in,
    input  logic  rdy_in,
    input  byte_t mem_din_i,
    output byte_t mem_dout_o,
    output addr_t mem_addr_o,
    output logic  mem_wr_o,
    output logic  halted_o
);

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      rd_we;
    reg_addr_t rd_addr;
    word_t     rd_data;

    mem_bus_if mem_bus ();

    cpu_core u_core (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .rdy_in     (rdy_in),
        .bus        (mem_bus.core),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .rd_we_o    (rd_we),
        .rd_addr_o  (rd_addr),
        .rd_data_o  (rd_data),
        .halted_o   (halted_o)
    );

    regfile u_regfile (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .raddr1_i (rs1_addr),
        .raddr2_i (rs2_addr),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data),
        .we_i     (rd_we),
        .waddr_i  (rd_addr),
        .wdata_i  (rd_data)
    );

    mem_ctrl u_mem_ctrl (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .rdy_in     (rdy_in),
        .bus        (mem_bus.ctrl),
        .mem_din_i  (mem_din_i),
        .mem_dout_o (mem_dout_o),
        .mem_addr_o (mem_addr_o),
        .mem_wr_o   (mem_wr_o)
    );

endmodule

`default_nettype wire

//--- tb/riscv_soc_assert.sv
// bus checks for the byte-serial memory controller
// bound into every mem_ctrl instance
`timescale 1ns/1ps
`default_nettype none

module riscv_soc_assert
    import bus_pkg::*;
(
    input  logic  clk_in,
    input  logic  rst_in,
    input  logic  rdy_in,
    input  logic  req_i,
    input  logic  done_i,
    input  logic  mem_wr_i,
    input  addr_t mem_addr_i
);

    // a request taken from the core and not answered yet
    logic req_open;

    always_ff @(posedge clk_in)
    begin
        if (rst_in)
        begin
            req_open <= 1'b0;
        end
        else if (rdy_in)
        begin
            if (req_i)
                req_open <= 1'b1;
            else if (done_i)
                req_open <= 1'b0;
        end
    end

    // no write strobe in reset or while the CPU is frozen
    wr_quiet: assert property (@(posedge clk_in) (rst_in || !rdy_in) |-> !mem_wr_i)
        else $error("mem_wr_o high during reset or pause");

    done_open: assert property (@(posedge clk_in) disable iff (rst_in)
        done_i |-> req_open)
        else $error("done without an open request");

    // write bytes go out on consecutive addresses
    addr_step: assert property (@(posedge clk_in) disable iff (rst_in)
        (mem_wr_i && $past(mem_wr_i)) |-> mem_addr_i == $past(mem_addr_i) + 32'd1)
        else $error("byte address did not step by one");

endmodule

bind mem_ctrl riscv_soc_assert u_bus_assert (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .rdy_in     (rdy_in),
    .req_i      (bus.req),
    .done_i     (done_q),
    .mem_wr_i   (mem_wr_o),
    .mem_addr_i (mem_addr_o)
);

`default_nettype wire

//--- tb/tb_riscv_soc.sv
// testbench for riscv_soc with a byte RAM model
// runs a small program per table row, with and without rdy_in pauses
`timescale 1ns/1ps
`default_nettype none

module tb_riscv_soc
    import cpu_pkg::*, bus_pkg::*;
();

    localparam int N_ROWS = 9;
    localparam int N_INSTR = 12;
    // 60 cycles per instruction in each run, doubled for pausing
    localparam int LIMIT = 60 * N_INSTR * 2;

    // row kinds
    localparam int K_ADD = 0, K_SUB = 1, K_AND = 2, K_OR = 3, K_XOR = 4;
    localparam int K_SLT = 5, K_BEQ = 6, K_JAL = 7;

    word_t tab_a [N_ROWS] = '{32'h1234_5678, 32'h0000_0010, 32'hF0F0_1234, 32'hA000_0005,
        32'hFFFF_0000, 32'hFFFF_FFFE, 32'h0000_0777, 32'h0000_0777, 32'h0000_0001};
    word_t tab_b [N_ROWS] = '{32'h0000_1111, 32'h0000_0020, 32'h0FF0_FFFF, 32'h0500_0800,
        32'h1234_5678, 32'h0000_0001, 32'h0000_0777, 32'h0000_0778, 32'h0000_0002};
    int    tab_kind [N_ROWS] = '{K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT, K_BEQ, K_BEQ, K_JAL};
    // beq skips the 0x55 marker when taken, jal links 16 + 4
    word_t tab_exp [N_ROWS] = '{32'h1234_6789, 32'hFFFF_FFF0, 32'h00F0_1234, 32'hA500_0805,
        32'hEDCB_5678, 32'h0000_0001, 32'h0000_0000, 32'h0000_0055, 32'h0000_0014};

    logic  clk_in = 1'b0;
    logic  rst_in = 1'b1;
    logic  rdy_in = 1'b1;
    logic  pause_en = 1'b0;
    byte_t mem_din_i = '0;
    byte_t mem_dout_o;
    addr_t mem_addr_o;
    logic  mem_wr_o;
    logic  halted_o;

    byte_t      ram [131072];
    word_t      prog [16];
    int         seed = 32'hade4f8e3;
    int         errors = 0;
    int         pass_runs = 0;
    int         fail_runs = 0;
    int         wr_count = 0;
    int         order_errs = 0;
    int         paused_wr = 0;
    int         io_count = 0;
    logic [1:0] wr_idx = '0;
    addr_t      wr_base = '0;

    riscv_soc DUT (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .rdy_in     (rdy_in),
        .mem_din_i  (mem_din_i),
        .mem_dout_o (mem_dout_o),
        .mem_addr_o (mem_addr_o),
        .mem_wr_o   (mem_wr_o),
        .halted_o   (halted_o)
    );

    always #2 clk_in = ~clk_in;

    always @(posedge clk_in)
    begin
        if (pause_en)
            rdy_in <= ($random(seed) & 3) != 0;
        else
            rdy_in <= 1'b1;
    end

    // byte RAM with reads one cycle late and writes landing at the edge
    always @(posedge clk_in)
    begin
        mem_din_i <= ram[mem_addr_o[16:0]];
        if (rst_in)
        begin
            wr_idx <= '0;
            // program at the bottom, an address pattern above it
            for (int i = 0; i < 8192; i++)
            begin
                ram[i] <= (i < 64) ? prog[i >> 2][((i & 3) * 8) +: 8] : byte_t'(i ^ (i >> 8));
            end
        end
        else if (mem_wr_o)
        begin
            wr_count <= wr_count + 1;
            wr_idx   <= wr_idx + 2'd1;
            if (!rdy_in)
                paused_wr <= paused_wr + 1;
            // each store starts word aligned and climbs one byte per cycle
            if (wr_idx == 2'd0)
            begin
                wr_base <= mem_addr_o;
                if (mem_addr_o[1:0] != 2'd0)
                    order_errs <= order_errs + 1;
            end
            else if (mem_addr_o != wr_base + addr_t'(wr_idx))
                order_errs <= order_errs + 1;
            if (mem_addr_o[17:16] == IO_SEL_HI)
                io_count <= io_count + 1;
            else
                ram[mem_addr_o[16:0]] <= mem_dout_o;
        end
    end

    function automatic word_t enc_u(logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, OP_LUI};
    endfunction

    function automatic word_t enc_i(logic [4:0] rd, logic [4:0] rs1, logic [2:0] f3,
                                    logic [11:0] imm, opcode_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_r(logic [6:0] f7, logic [4:0] rd, logic [2:0] f3);
        // always rd = x1 op x2
        return {f7, 5'd2, 5'd1, f3, rd, OP_REG};
    endfunction

    function automatic word_t enc_sw(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic word_t enc_beq(logic [4:0] rs1, logic [4:0] rs2, logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic word_t enc_jal(logic [4:0] rd, logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    function automatic word_t read_word(int base);
        return {ram[base + 3], ram[base + 2], ram[base + 1], ram[base]};
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t expected);
        if (got !== expected)
        begin
            $display("** Error: %s got 0x%08h expected 0x%08h", name, got, expected);
            errors++;
        end
    endtask

    // load a and b with lui/addi, run the row's operation, store and reload
    task automatic build_program(input int r);
        word_t a;
        word_t b;
        a = tab_a[r];
        b = tab_b[r];
        for (int i = 0; i < 16; i++)
            prog[i] = '0;
        prog[0] = enc_u(5'd1, 20'((a + 32'h800) >> 12));
        prog[1] = enc_i(5'd1, 5'd1, 3'b000, a[11:0], OP_IMM);
        prog[2] = enc_u(5'd2, 20'((b + 32'h800) >> 12));
        prog[3] = enc_i(5'd2, 5'd2, 3'b000, b[11:0], OP_IMM);
        prog[5] = enc_i(5'd0, 5'd0, 3'b000, 12'h000, OP_IMM);
        case (tab_kind[r])
            K_ADD: prog[4] = enc_r(7'h00, 5'd3, 3'b000);
            K_SUB: prog[4] = enc_r(7'h20, 5'd3, 3'b000);
            K_AND: prog[4] = enc_r(7'h00, 5'd3, 3'b111);
            K_OR:  prog[4] = enc_r(7'h00, 5'd3, 3'b110);
            K_XOR: prog[4] = enc_r(7'h00, 5'd3, 3'b100);
            K_SLT: prog[4] = enc_r(7'h00, 5'd3, 3'b010);
            K_BEQ:
            begin
                prog[4] = enc_beq(5'd1, 5'd2, 13'd8);
                prog[5] = enc_i(5'd3, 5'd0, 3'b000, 12'h055, OP_IMM);
            end
            default:
            begin
                prog[4] = enc_jal(5'd3, 21'd8);
                prog[5] = enc_i(5'd3, 5'd0, 3'b000, 12'h055, OP_IMM);
            end
        endcase
        prog[6]  = enc_u(5'd5, 20'h00001);
        prog[7]  = enc_sw(5'd3, 5'd5, 12'h000);
        prog[8]  = enc_i(5'd4, 5'd5, 3'b010, 12'h000, OP_LOAD);
        prog[9]  = enc_sw(5'd4, 5'd5, 12'h004);
        prog[10] = enc_u(5'd6, 20'h00030);
        prog[11] = enc_sw(5'd4, 5'd6, 12'h004);
    endtask

    task automatic run_row(input int r, input logic paused);
        int    err0;
        int    io0;
        int    cycles;
        int    wr0;
        word_t got0;
        build_program(r);
        err0 = errors;
        io0  = io_count;
        @(posedge clk_in);
        rst_in   <= 1'b1;
        pause_en <= 1'b0;
        repeat (5) @(posedge clk_in);
        rst_in   <= 1'b0;
        pause_en <= paused;
        cycles = 0;
        @(negedge clk_in);
        while (!halted_o && cycles < LIMIT)
        begin
            @(negedge clk_in);
            cycles++;
        end
        if (!halted_o)
        begin
            $display("row %0d (pause %0d) hung, halted_o never went high", r, paused);
            $display("Test failed");
            $finish;
        end
        else
        begin
            // the bus must stay quiet once halted
            wr0 = wr_count;
            repeat (50) @(negedge clk_in);
            check_value("writes_after_halt", word_t'(wr_count - wr0), 32'h0);
            // the stop store puts its four bytes on the I/O region
            check_value("io_writes", word_t'(io_count - io0), 32'd4);
            got0 = read_word(32'h1000);
            check_value("mem[0x1000]", got0, tab_exp[r]);
            check_value("mem[0x1004]", read_word(32'h1004), got0);
            check_value("byte_order_errors", word_t'(order_errs), 32'h0);
            check_value("writes_while_paused", word_t'(paused_wr), 32'h0);
            if (errors == err0)
                pass_runs++;
            else
                fail_runs++;
            $display("row %0d pause %0d: %s (%0d cycles)", r, paused,
                     (errors == err0) ? "ok" : "FAIL", cycles);
        end
    endtask

    initial
    begin
        for (int r = 0; r < N_ROWS; r++)
        begin
            run_row(r, 1'b0);
            run_row(r, 1'b1);
        end
        $display("runs passed %0d, failed %0d, errors %0d, io writes %0d",
                 pass_runs, fail_runs, errors, io_count);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
source/cpu_pkg.sv
source/bus_pkg.sv
source/mem_bus_if.sv
source/mem_ctrl.sv
source/regfile.sv
source/cpu_core.sv
source/riscv_soc.sv
tb/riscv_soc_assert.sv
tb/tb_riscv_soc.sv

//--- run_sim.sh
#!/bin/sh
# build and run the riscv_soc testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_riscv_soc \
    --Mdir obj_dir -o tb_riscv_soc
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_riscv_soc > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0
